// File: source/puf_pkg.sv
package puf_pkg;

	// oscillator bank and challenge
	localparam int RO_NUM      = 16;                // oscillators in the bank
	localparam int SEL_W       = $clog2(RO_NUM);    // one oscillator index
	localparam int CHAL_W      = 2 * SEL_W;         // select 1 high nibble and select 0 low nibble

	// race counters
	localparam int CNT_W       = 10;                // edge counter width
	localparam int CNT_MAX     = 2**CNT_W - 1;      // count at which a counter is full
	localparam int SYNC_STAGES = 2;                 // flops per oscillator synchronizer

	// response frame goes out lsb first
	localparam int FRAME_W      = 1 + CNT_W + CHAL_W;    // resp + loser count + challenge
	localparam int FRM_RESP     = 0;                     // response bit position
	localparam int FRM_CNT_LSB  = FRM_RESP + 1;          // loser count field
	localparam int FRM_CHAL_LSB = FRM_CNT_LSB + CNT_W;   // echoed challenge field

	// serial link bit counters
	localparam int RX_CNT_W    = $clog2(CHAL_W);        // wraps after the last challenge bit
	localparam int TX_CNT_W    = $clog2(FRAME_W + 1);   // holds FRAME_W down to zero

endpackage

// File: source/puf_challenge_rx.sv
`timescale 1ns/1ps

module puf_challenge_rx
	import puf_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_rx_valid,   // host has a bit on i_rx_data
	input  logic              i_rx_data,    // challenge bit, msb first
	input  logic              i_arm,        // reopen for the next challenge
	output logic              o_rx_ready,   // high while waiting for a challenge
	output logic              o_chal_valid, // one cycle after the eighth bit
	output logic [CHAL_W-1:0] o_chal        // held until the next arm
);

	logic [RX_CNT_W-1:0] bit_cnt; // bits taken so far
	logic [CHAL_W-1:0]   shreg;   // challenge shift register
	logic                take;    // handshake on this edge

	assign take = i_rx_valid & o_rx_ready;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			o_rx_ready   <= 1'b1;
			o_chal_valid <= 1'b0;
			bit_cnt      <= '0;
		end else begin
			o_chal_valid <= 1'b0; // pulse by default
			if (i_arm) begin
				o_rx_ready <= 1'b1;
				bit_cnt    <= '0;
			end else if (take) begin
				bit_cnt <= bit_cnt + 1'b1; // wraps to zero after the last bit
				if (bit_cnt == RX_CNT_W'(CHAL_W - 1)) begin
					o_rx_ready   <= 1'b0; // stop taking bits once full
					o_chal_valid <= 1'b1;
				end
			end
		end
	end

	// first bit ends up in the msb
	always_ff @(posedge clk) begin
		if (take) begin
			shreg <= {shreg[CHAL_W-2:0], i_rx_data};
		end
	end

	assign o_chal = shreg;

endmodule

// File: source/puf_ro_select.sv
`timescale 1ns/1ps

module puf_ro_select
	import puf_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_meas_en, // measurement window
	input  logic [CHAL_W-1:0] i_chal,    // two oscillator indices
	input  logic [RO_NUM-1:0] i_ro,      // raw oscillator lines
	output logic [RO_NUM-1:0] o_ro_en,   // one enable per oscillator
	output logic              o_ro_0,    // synchronized line picked by select 0
	output logic              o_ro_1     // synchronized line picked by select 1
);

	logic [SEL_W-1:0]       sel  [2]; // lane 0 low nibble, lane 1 high nibble
	logic [SYNC_STAGES-1:0] sync [2]; // synchronizer chain per lane

	assign sel[0] = i_chal[SEL_W-1:0];
	assign sel[1] = i_chal[CHAL_W-1:SEL_W];

	// one-hot per select where equal selects collapse to a single bit
	always_comb begin
		o_ro_en = '0;
		if (i_meas_en) begin
			o_ro_en[sel[0]] = 1'b1;
			o_ro_en[sel[1]] = 1'b1;
		end
	end

	// 16-to-1 mux straight into the first sync flop
	always_ff @(posedge clk) begin
		for (int lane = 0; lane < 2; lane++) begin
			if (i_rst) begin
				sync[lane] <= '0;
			end else begin
				sync[lane] <= {sync[lane][SYNC_STAGES-2:0], i_ro[sel[lane]]};
			end
		end
	end

	assign o_ro_0 = sync[0][SYNC_STAGES-1];
	assign o_ro_1 = sync[1][SYNC_STAGES-1];

endmodule

// File: source/puf_edge_counter.sv
`timescale 1ns/1ps

module puf_edge_counter
	import puf_pkg::*;
(
	input  logic             clk,
	input  logic             i_rst,
	input  logic             i_meas_en, // count window
	input  logic             i_ro,      // already synchronized oscillator line
	output logic [CNT_W-1:0] o_cnt,     // rising edges seen in this window
	output logic             o_full     // count reached CNT_MAX
);

	logic meas_d;    // window delayed one cycle
	logic ro_d;      // line delayed one cycle
	logic meas_rise; // first cycle of a new window
	logic ro_rise;   // 0 -> 1 on the line

	assign meas_rise = i_meas_en & ~meas_d;
	assign ro_rise   = i_ro & ~ro_d;
	assign o_full    = (o_cnt == CNT_W'(CNT_MAX));

	always_ff @(posedge clk) begin
		if (i_rst) begin
			meas_d <= 1'b0;
			ro_d   <= 1'b0;
			o_cnt  <= '0;
		end else begin
			meas_d <= i_meas_en;
			ro_d   <= i_ro;
			if (meas_rise) begin
				o_cnt <= '0; // fresh window
			end else if (i_meas_en && ro_rise && !o_full) begin
				o_cnt <= o_cnt + 1'b1; // saturates at CNT_MAX
			end
		end
	end

endmodule

// File: source/puf_race_arbiter.sv
`timescale 1ns/1ps

module puf_race_arbiter
	import puf_pkg::*;
(
	input  logic             clk,
	input  logic             i_rst,
	input  logic             i_meas_en,
	input  logic             i_full_0,
	input  logic             i_full_1,
	input  logic [CNT_W-1:0] i_cnt_0,
	input  logic [CNT_W-1:0] i_cnt_1,
	output logic             o_race_done, // one pulse per measurement
	output logic             o_resp,      // 1 when oscillator 1 wins alone
	output logic [CNT_W-1:0] o_loser_cnt  // count of the other counter
);

	logic armed;  // cleared after the decision and set again outside the window
	logic meas_d; // counters still hold old values in the first window cycle
	logic fire;   // decision cycle

	// skip the first cycle since counters clear on that edge
	assign fire = armed & i_meas_en & meas_d & (i_full_0 | i_full_1);

	always_ff @(posedge clk) begin
		if (i_rst) begin
			armed       <= 1'b1;
			meas_d      <= 1'b0;
			o_race_done <= 1'b0;
		end else begin
			meas_d      <= i_meas_en;
			o_race_done <= fire;
			if (fire) begin
				armed <= 1'b0;
			end else if (!i_meas_en) begin
				armed <= 1'b1; // window closed
			end
		end
	end

	// tie goes to oscillator 0 so resp stays 0 when both are full
	always_ff @(posedge clk) begin
		if (fire) begin
			o_resp      <= i_full_1 & ~i_full_0;
			o_loser_cnt <= (i_full_1 & ~i_full_0) ? i_cnt_0 : i_cnt_1;
		end
	end

endmodule

// File: source/puf_measure_ctrl.sv
`timescale 1ns/1ps

module puf_measure_ctrl (
	input  logic clk,
	input  logic i_rst,
	input  logic i_chal_valid, // challenge complete
	input  logic i_race_done,  // a counter filled up
	input  logic i_tx_done,    // frame fully sent
	output logic o_meas_en,    // level for the whole race
	output logic o_frame_load, // capture the frame and also exec done
	output logic o_rx_arm      // reopen the receiver
);

	typedef enum logic [1:0] {
		ST_IDLE,     // waiting for a challenge
		ST_MEASURE,  // oscillators running
		ST_TRANSMIT, // frame going out
		ST_REARM     // one cycle to reopen rx
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE:     if (i_chal_valid) state_nxt = ST_MEASURE;
			ST_MEASURE:  if (i_race_done)  state_nxt = ST_TRANSMIT;
			ST_TRANSMIT: if (i_tx_done)    state_nxt = ST_REARM;
			default:                       state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			state        <= ST_IDLE;
			o_frame_load <= 1'b0;
		end else begin
			state        <= state_nxt;
			o_frame_load <= (state == ST_MEASURE) & i_race_done; // one cycle after race done
		end
	end

	assign o_meas_en = (state == ST_MEASURE);
	assign o_rx_arm  = (state == ST_REARM); // rx ready rises the cycle after

endmodule

// File: source/puf_frame_tx.sv
`timescale 1ns/1ps

module puf_frame_tx
	import puf_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_load,      // capture a new frame only when idle
	input  logic              i_resp,
	input  logic              i_tx_ready,  // host back-pressure
	input  logic [CNT_W-1:0]  i_loser_cnt,
	input  logic [CHAL_W-1:0] i_chal,
	output logic              o_tx_valid,  // bits remain
	output logic              o_tx_data,   // current bit, lsb first
	output logic              o_tx_done    // pulse after the last bit
);

	logic [FRAME_W-1:0]  frame;    // assembled frame
	logic [FRAME_W-1:0]  shreg;    // shifts right on each accepted bit
	logic [TX_CNT_W-1:0] bits_left;
	logic                accept;   // host took the current bit

	always_comb begin
		frame                             = '0;
		frame[FRM_RESP]                   = i_resp;
		frame[FRM_CNT_LSB +: CNT_W]       = i_loser_cnt;
		frame[FRM_CHAL_LSB +: CHAL_W]     = i_chal;
	end

	assign o_tx_valid = (bits_left != '0);
	assign o_tx_data  = shreg[0];
	assign accept     = o_tx_valid & i_tx_ready;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			bits_left <= '0;
			o_tx_done <= 1'b0;
		end else begin
			o_tx_done <= accept && (bits_left == TX_CNT_W'(1)); // last bit taken
			if (i_load) begin
				bits_left <= TX_CNT_W'(FRAME_W);
			end else if (accept) begin
				bits_left <= bits_left - 1'b1;
			end
		end
	end

	// bit holds while ready is low
	always_ff @(posedge clk) begin
		if (i_load) begin
			shreg <= frame;
		end else if (accept) begin
			shreg <= {1'b0, shreg[FRAME_W-1:1]};
		end
	end

endmodule

// File: source/puf_datapath.sv
`timescale 1ns/1ps

module puf_datapath
	import puf_pkg::*;
(
	input  logic              clk,
	input  logic              i_rst,
	input  logic              i_rx_valid,
	input  logic              i_rx_data,
	input  logic              i_tx_ready,
	input  logic [RO_NUM-1:0] i_ro,        // lines back from the oscillator bank
	output logic              o_rx_ready,
	output logic [RO_NUM-1:0] o_ro_en,     // enables out to the oscillator bank
	output logic              o_exec_done, // frame loaded
	output logic              o_tx_valid,
	output logic              o_tx_data,
	output logic              o_tx_done
);

	logic              chal_valid;
	logic [CHAL_W-1:0] chal;
	logic              rx_arm;
	logic              meas_en;
	logic              ro_0;           // synchronized selected lines
	logic              ro_1;
	logic [CNT_W-1:0]  cnt_0;
	logic [CNT_W-1:0]  cnt_1;
	logic              full_0;
	logic              full_1;
	logic              race_done;
	logic              resp;
	logic [CNT_W-1:0]  loser_cnt;
	logic              frame_load;

	puf_challenge_rx u_rx (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_rx_valid   (i_rx_valid),
		.i_rx_data    (i_rx_data),
		.i_arm        (rx_arm),
		.o_rx_ready   (o_rx_ready),
		.o_chal_valid (chal_valid),
		.o_chal       (chal)
	);

	puf_measure_ctrl u_ctrl (
		.clk          (clk),
		.i_rst        (i_rst),
		.i_chal_valid (chal_valid),
		.i_race_done  (race_done),
		.i_tx_done    (o_tx_done),
		.o_meas_en    (meas_en),
		.o_frame_load (frame_load),
		.o_rx_arm     (rx_arm)
	);

	puf_ro_select u_sel (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_meas_en (meas_en),
		.i_chal    (chal),
		.i_ro      (i_ro),
		.o_ro_en   (o_ro_en),
		.o_ro_0    (ro_0),
		.o_ro_1    (ro_1)
	);

	puf_edge_counter u_cnt_0 (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_meas_en (meas_en),
		.i_ro      (ro_0),
		.o_cnt     (cnt_0),
		.o_full    (full_0)
	);

	puf_edge_counter u_cnt_1 (
		.clk       (clk),
		.i_rst     (i_rst),
		.i_meas_en (meas_en),
		.i_ro      (ro_1),
		.o_cnt     (cnt_1),
		.o_full    (full_1)
	);

	puf_race_arbiter u_arb (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_meas_en   (meas_en),
		.i_full_0    (full_0),
		.i_full_1    (full_1),
		.i_cnt_0     (cnt_0),
		.i_cnt_1     (cnt_1),
		.o_race_done (race_done),
		.o_resp      (resp),
		.o_loser_cnt (loser_cnt)
	);

	puf_frame_tx u_tx (
		.clk         (clk),
		.i_rst       (i_rst),
		.i_load      (frame_load),
		.i_resp      (resp),
		.i_tx_ready  (i_tx_ready),
		.i_loser_cnt (loser_cnt),
		.i_chal      (chal),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data),
		.o_tx_done   (o_tx_done)
	);

	assign o_exec_done = frame_load; // host sees the load strobe

endmodule

// File: tb/puf_tb_assert.sv
`timescale 1ns/1ps

module puf_tb_assert
	import puf_pkg::*;
(
	input logic              clk,
	input logic              i_rst,
	input logic              i_meas_en,   // internal measurement window
	input logic [RO_NUM-1:0] i_ro_en,
	input logic              i_tx_valid,
	input logic              i_tx_ready,
	input logic              i_tx_data,
	input logic              i_exec_done
);

	// only the two selected oscillators may run
	a_two_en: assert property (@(posedge clk) disable iff (i_rst)
		$countones(i_ro_en) <= 2)
		else $error("more than two oscillator enables set");

	a_en_idle: assert property (@(posedge clk) disable iff (i_rst)
		!i_meas_en |-> (i_ro_en == '0))
		else $error("oscillator enable set outside a measurement");

	// stalled bit holds until the host takes it
	a_tx_hold: assert property (@(posedge clk) disable iff (i_rst)
		(i_tx_valid && !i_tx_ready) |=> (i_tx_valid && $stable(i_tx_data)))
		else $error("tx bit changed under back-pressure");

	a_exec_pulse: assert property (@(posedge clk) disable iff (i_rst)
		i_exec_done |=> !i_exec_done)
		else $error("exec done longer than one cycle");

endmodule

bind puf_datapath puf_tb_assert u_assert (
	.clk         (clk),
	.i_rst       (i_rst),
	.i_meas_en   (meas_en),
	.i_ro_en     (o_ro_en),
	.i_tx_valid  (o_tx_valid),
	.i_tx_ready  (i_tx_ready),
	.i_tx_data   (o_tx_data),
	.i_exec_done (o_exec_done)
);

// File: tb/puf_tb.sv
`timescale 1ns/1ps

module puf_tb
	import puf_pkg::*;
();

	localparam int MAX_HALF = 5;  // slowest oscillator half period in clk cycles
	localparam int N_TESTS  = 9;  // reset, seven challenges, done count
	localparam int TIMEOUT  = N_TESTS * (CNT_MAX * 2 * MAX_HALF + 200);
	localparam int CNT_TOL  = 3;  // sync phase slack on the loser count

	logic              clk;
	logic              i_rst;
	logic              i_rx_valid;
	logic              i_rx_data;
	logic              i_tx_ready;
	logic [RO_NUM-1:0] i_ro;
	logic              o_rx_ready;
	logic [RO_NUM-1:0] o_ro_en;
	logic              o_exec_done;
	logic              o_tx_valid;
	logic              o_tx_data;
	logic              o_tx_done;

	integer             seed = 32'h0078_d971;
	int                 cycles = 0;
	int                 err_cnt = 0;
	int                 n_pass = 0;
	int                 n_fail = 0;
	int                 done_cnt = 0;    // o_tx_done pulses seen
	int                 bit_idx = 0;     // next frame bit from the link
	int                 ro_tick [RO_NUM];
	string              cur_name = "reset";
	logic [FRAME_W-1:0] rx_word;
	logic [CHAL_W-1:0]  chal_q [$];      // challenges waiting for their frame
	logic [FRAME_W-1:0] got_q [$];       // frames collected from the link

	puf_datapath i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// toggle interval per oscillator in clk cycles
	function automatic int half_of(input int k);
		return 2 + ((k * 3) % 4);
	endfunction

	function automatic logic [RO_NUM-1:0] exp_enables(input logic [CHAL_W-1:0] chal);
		logic [RO_NUM-1:0] en;
		en = '0;
		en[chal[SEL_W-1:0]]      = 1'b1;
		en[chal[CHAL_W-1:SEL_W]] = 1'b1; // same index just sets one bit
		return en;
	endfunction

	// faster oscillator fills first and ties go to select 0
	function automatic logic [FRAME_W-1:0] exp_frame(input logic [CHAL_W-1:0] chal);
		int                 h0;
		int                 h1;
		int                 loser;
		logic               resp;
		logic [FRAME_W-1:0] f;
		h0    = half_of(chal[SEL_W-1:0]);
		h1    = half_of(chal[CHAL_W-1:SEL_W]);
		resp  = (h1 < h0);
		loser = resp ? (CNT_MAX * h1 / h0) : (CNT_MAX * h0 / h1);
		f                           = '0;
		f[FRM_RESP]                 = resp;
		f[FRM_CNT_LSB +: CNT_W]     = CNT_W'(loser);
		f[FRM_CHAL_LSB +: CHAL_W]   = chal;
		return f;
	endfunction

	task automatic report_mismatch(input string what, input int exp, input int act);
		$display("error %s %s: expected 'h%0h, actual 'h%0h", cur_name, what, exp, act);
		err_cnt++;
	endtask

	task automatic check_frame(input logic [FRAME_W-1:0] got);
		logic [CHAL_W-1:0]  chal;
		logic [FRAME_W-1:0] exp;
		int                 exp_cnt;
		int                 got_cnt;
		int                 tol;
		if (chal_q.size() == 0) begin
			$display("error %s: a frame arrived with no challenge sent", cur_name);
			err_cnt++;
			return;
		end
		chal    = chal_q.pop_front();
		exp     = exp_frame(chal);
		exp_cnt = exp[FRM_CNT_LSB +: CNT_W];
		got_cnt = got[FRM_CNT_LSB +: CNT_W];
		tol     = (exp_cnt == CNT_MAX) ? 0 : CNT_TOL; // equal rates fill together
		if (got[FRM_CHAL_LSB +: CHAL_W] != chal)
			report_mismatch("challenge field", chal, got[FRM_CHAL_LSB +: CHAL_W]);
		if (got[FRM_RESP] != exp[FRM_RESP])
			report_mismatch("response bit", exp[FRM_RESP], got[FRM_RESP]);
		if (got_cnt < exp_cnt - tol || got_cnt > exp_cnt + tol)
			report_mismatch("loser count", exp_cnt, got_cnt);
	endtask

	task automatic finish_test(input int errs0);
		if (err_cnt == errs0) begin
			n_pass++;
			$display("test %s passed", cur_name);
		end else begin
			n_fail++;
			$display("test %s failed", cur_name);
		end
	endtask

	// one challenge in and one frame out with junk bits offered while busy if asked
	task automatic run_challenge(input string name, input logic [CHAL_W-1:0] chal,
			input bit offer_busy);
		int                errs0;
		int                i;
		int                wait_cyc;
		logic [RO_NUM-1:0] en_exp;
		cur_name = name;
		errs0    = err_cnt;
		en_exp   = exp_enables(chal);
		do @(negedge clk); while (!o_rx_ready);
		@(posedge clk);
		#1;
		chal_q.push_back(chal);
		for (i = CHAL_W - 1; i >= 0; i--) begin
			i_rx_valid = 1'b1;
			i_rx_data  = chal[i]; // msb first
			@(posedge clk);
			#1;
		end
		i_rx_valid = 1'b0;
		i_rx_data  = 1'b0;
		do @(negedge clk); while (o_ro_en == '0);
		if (o_ro_en != en_exp)
			report_mismatch("o_ro_en", en_exp, o_ro_en);
		if (offer_busy) begin
			@(posedge clk);
			#1;
			i_rx_valid = 1'b1; // should be ignored while ready is low
			i_rx_data  = 1'b1;
			repeat (4) begin
				@(negedge clk);
				if (o_rx_ready) begin
					$display("error %s: o_rx_ready is high during a measurement", name);
					err_cnt++;
				end
			end
			@(posedge clk);
			#1;
			i_rx_valid = 1'b0;
			i_rx_data  = 1'b0;
		end
		do @(negedge clk); while (!o_exec_done);
		if (o_ro_en != '0)
			report_mismatch("o_ro_en after exec done", 0, o_ro_en);
		do @(negedge clk); while (!o_tx_done);
		wait_cyc = 0;
		do begin
			@(negedge clk);
			wait_cyc++;
		end while (!o_rx_ready);
		if (wait_cyc != 2)
			report_mismatch("o_rx_ready delay after o_tx_done", 2, wait_cyc);
		finish_test(errs0);
	endtask

	// each oscillator line toggles every half_of(k) cycles while enabled
	always @(posedge clk) begin
		int k;
		#1;
		for (k = 0; k < RO_NUM; k++) begin
			if (!o_ro_en[k]) begin
				i_ro[k]    = 1'b0;
				ro_tick[k] = 0;
			end else if (ro_tick[k] == half_of(k) - 1) begin
				i_ro[k]    = ~i_ro[k];
				ro_tick[k] = 0;
			end else begin
				ro_tick[k]++;
			end
		end
	end

	// host back-pressure with ready about three cycles in four
	always @(posedge clk) begin
		#1;
		i_tx_ready = (($random(seed) & 3) != 0);
	end

	// link sampled mid-cycle since a bit moves on the next rising edge
	always @(negedge clk) begin
		if (o_tx_done)
			done_cnt++;
		if (!i_rst && o_tx_valid && i_tx_ready) begin
			rx_word[bit_idx] = o_tx_data; // lsb first
			if (bit_idx == FRAME_W - 1) begin
				got_q.push_back(rx_word);
				bit_idx = 0;
			end else begin
				bit_idx++;
			end
		end
	end

	always @(negedge clk) begin
		if (got_q.size() > 0)
			check_frame(got_q.pop_front());
	end

	// run limit in clk cycles
	initial begin
		while (cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int errs0;
		i_rst      = 1'b1;
		i_rx_valid = 1'b0;
		i_rx_data  = 1'b0;
		i_tx_ready = 1'b0;
		i_ro       = '0;
		for (int k = 0; k < RO_NUM; k++)
			ro_tick[k] = 0;
		repeat (5) @(posedge clk);
		#1;
		i_rst = 1'b0;

		@(negedge clk);
		errs0 = err_cnt;
		if (o_rx_ready !== 1'b1)
			report_mismatch("o_rx_ready", 1, o_rx_ready);
		if (o_ro_en !== '0)
			report_mismatch("o_ro_en", 0, o_ro_en);
		if (o_tx_valid !== 1'b0)
			report_mismatch("o_tx_valid", 0, o_tx_valid);
		if (o_tx_done !== 1'b0)
			report_mismatch("o_tx_done", 0, o_tx_done);
		if (o_exec_done !== 1'b0)
			report_mismatch("o_exec_done", 0, o_exec_done);
		finish_test(errs0);

		run_challenge("slow_sel1", 8'h10, 1'b0);  // 5 vs 2 so select 0 wins
		run_challenge("fast_sel1", 8'h02, 1'b0);  // 2 vs 4 so select 1 wins
		run_challenge("same_osc", 8'h33, 1'b0);   // single enable and a tie
		run_challenge("equal_rate", 8'h40, 1'b0); // two oscillators at the same rate
		run_challenge("mid_rates", 8'h7D, 1'b0);  // 3 vs 5
		run_challenge("busy_offer", 8'hC9, 1'b1);
		run_challenge("after_busy", 8'h5E, 1'b0); // 5 vs 4 so select 0 wins

		cur_name = "done_count";
		errs0    = err_cnt;
		if (done_cnt != 7)
			report_mismatch("o_tx_done pulses", 7, done_cnt);
		if (chal_q.size() != 0) begin
			$display("error %s: %0d frames never arrived", cur_name, chal_q.size());
			err_cnt++;
		end
		finish_test(errs0);

		$display("%0d tests, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
		if (n_fail == 0 && err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: verilog.f
source/puf_pkg.sv
source/puf_challenge_rx.sv
source/puf_ro_select.sv
source/puf_edge_counter.sv
source/puf_race_arbiter.sv
source/puf_measure_ctrl.sv
source/puf_frame_tx.sv
source/puf_datapath.sv
tb/puf_tb_assert.sv
tb/puf_tb.sv
